/* logic/mm_defines.svh */
`ifndef MM_DEFINES_SVH
`define MM_DEFINES_SVH

// ------------------------------------------------------------
// datapath widths
// ------------------------------------------------------------
`define MM_W_D            32  // data word
`define MM_SIMD           2   // lanes per memory word
`define MM_LOG_SIMD       1
`define MM_W_A            7   // element address, N up to 128
`define MM_W_MEM_A        (`MM_W_A - `MM_LOG_SIMD)

// ------------------------------------------------------------
// depths and latencies
// ------------------------------------------------------------
`define MM_FIFO_DEPTH_LOG 2   // 4 entries
`define MM_MULT_LATENCY   7   // enable to valid

// accumulate + reduce + pack slack after last issue
`define MM_DRAIN_CYCLES   (`MM_MULT_LATENCY + `MM_SIMD + 4)

`endif

/* logic/mm_pkg.sv */
`default_nettype none

`include "mm_defines.svh"

package mm_pkg;

  typedef logic [`MM_W_D-1:0]          word_t;
  typedef logic [`MM_SIMD*`MM_W_D-1:0] lane_vec_t;  // lane 0 in low bits
  typedef logic [`MM_W_MEM_A-1:0]      lane_addr_t;

  // sequencer states
  typedef enum logic [3:0] {
    idle, size_wait, size_take,
    batch_idle, batch_wait, batch_take,
    issue, drain, reply
  } seq_state_t;

endpackage

`default_nettype wire

/* logic/mm_word_fifo.sv */
`default_nettype none

`include "mm_defines.svh"

module mm_word_fifo import mm_pkg::*; (
  input  logic  CLK,
  input  logic  RST,
  input  logic  enq,
  input  word_t data,
  input  logic  deq,
  output word_t q,
  output logic  empty,
  output logic  full
);

  localparam int DEPTH = 1 << `MM_FIFO_DEPTH_LOG;

  word_t                         mem [DEPTH];
  logic [`MM_FIFO_DEPTH_LOG-1:0] wr_ptr;
  logic [`MM_FIFO_DEPTH_LOG-1:0] rd_ptr;
  logic [`MM_FIFO_DEPTH_LOG:0]   count;  // one extra bit for full
  logic                          do_enq;
  logic                          do_deq;

  assign do_enq = enq && !full;   // drop on full
  assign do_deq = deq && !empty;
  assign empty  = (count == '0);
  assign full   = count[`MM_FIFO_DEPTH_LOG];

  // storage and registered head
  always_ff @(posedge CLK) begin
    if (do_enq) begin
      mem[wr_ptr] <= data;
    end
    if (do_deq) begin
      q <= mem[rd_ptr];  // valid the cycle after deq
    end
  end

  always_ff @(posedge CLK) begin
    if (RST) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_enq) wr_ptr <= wr_ptr + 1'b1;
      if (do_deq) rd_ptr <= rd_ptr + 1'b1;
      case ({do_enq, do_deq})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // both or neither
      endcase
    end
  end

endmodule

`default_nettype wire

/* logic/mm_lane_ram.sv */
`default_nettype none

`include "mm_defines.svh"

module mm_lane_ram import mm_pkg::*; (
  input  logic       CLK,
  input  logic       we,
  input  lane_addr_t waddr,
  input  lane_vec_t  wdata,
  input  lane_addr_t raddr,
  output lane_vec_t  rdata
);

  // one lane word per entry
  lane_vec_t mem [1 << `MM_W_MEM_A];

  always_ff @(posedge CLK) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
    rdata <= mem[raddr];  // old data on same-address collision
  end

endmodule

`default_nettype wire

/* logic/mm_sequencer.sv */
`default_nettype none

`include "mm_defines.svh"

module mm_sequencer import mm_pkg::*; (
  input  logic       CLK,
  input  logic       RST,
  input  word_t      cmd_q,
  input  logic       cmd_empty,
  output logic       cmd_deq,
  output logic       reply_enq,
  output word_t      reply_data,
  output lane_addr_t a_raddr,
  output lane_addr_t b_raddr,
  input  lane_vec_t  a_rdata,
  input  lane_vec_t  b_rdata,
  output logic       op_valid,
  output lane_vec_t  op_a,
  output lane_vec_t  op_b,
  output logic       session_clear,
  output word_t      matrix_size
);

  seq_state_t state;
  word_t      batch_len;   // lane words in this batch
  word_t      issue_cnt;
  logic [7:0] drain_cnt;
  logic       page;        // B half in use
  word_t      cycle_cnt;   // since session start
  logic       rd_valid_q;  // ram data valid this cycle
  lane_addr_t a_last;

  assign a_last = lane_addr_t'((matrix_size >> `MM_LOG_SIMD) - 1);

  // ------------------------------------------------------------
  // command / issue FSM
  // ------------------------------------------------------------
  always_ff @(posedge CLK) begin
    if (RST) begin
      state         <= idle;
      cmd_deq       <= 1'b0;
      reply_enq     <= 1'b0;
      session_clear <= 1'b0;
      matrix_size   <= '0;
      batch_len     <= '0;
      issue_cnt     <= '0;
      drain_cnt     <= '0;
      page          <= 1'b0;
      a_raddr       <= '0;
      b_raddr       <= '0;
    end else begin
      cmd_deq       <= 1'b0;  // strobes default low
      reply_enq     <= 1'b0;
      session_clear <= 1'b0;
      case (state)
        idle: begin
          if (!cmd_empty) begin
            cmd_deq <= 1'b1;
            state   <= size_wait;
          end
        end
        size_wait: begin
          session_clear <= 1'b1;  // high during size_take
          state         <= size_take;
        end
        size_take: begin
          matrix_size <= cmd_q;
          a_raddr     <= '0;
          page        <= 1'b0;
          state       <= batch_idle;
        end
        batch_idle: begin
          if (!cmd_empty) begin
            cmd_deq <= 1'b1;
            state   <= batch_wait;
          end
        end
        batch_wait: state <= batch_take;
        batch_take: begin
          if (cmd_q == '0) begin
            state <= idle;  // end of session
          end else begin
            batch_len <= cmd_q;
            issue_cnt <= '0;
            b_raddr   <= {page, {(`MM_W_MEM_A-1){1'b0}}};  // page base
            state     <= issue;
          end
        end
        issue: begin
          // read at current addresses, then advance
          a_raddr   <= (a_raddr == a_last) ? '0 : a_raddr + 1'b1;
          b_raddr   <= b_raddr + 1'b1;
          issue_cnt <= issue_cnt + 1'b1;
          if (issue_cnt == batch_len - 1'b1) begin
            drain_cnt <= '0;
            state     <= drain;
          end
        end
        drain: begin
          drain_cnt <= drain_cnt + 1'b1;
          if (drain_cnt == 8'(`MM_DRAIN_CYCLES - 1)) state <= reply;
        end
        reply: begin
          reply_enq <= 1'b1;  // host drains before next cmd
          page      <= ~page;
          state     <= batch_idle;
        end
        default: state <= idle;
      endcase
    end
  end

  // operand stage one cycle behind the ram read
  always_ff @(posedge CLK) begin
    if (RST) begin
      rd_valid_q <= 1'b0;
      op_valid   <= 1'b0;
      cycle_cnt  <= '0;
    end else begin
      rd_valid_q <= (state == issue);
      op_valid   <= rd_valid_q;
      cycle_cnt  <= session_clear ? '0 : cycle_cnt + 1'b1;
    end
  end

  always_ff @(posedge CLK) begin
    if (rd_valid_q) begin
      op_a <= a_rdata;
      op_b <= b_rdata;
    end
    if (state == reply) reply_data <= cycle_cnt;
  end

endmodule

`default_nettype wire

/* logic/mm_signed_mult.sv */
`default_nettype none

`include "mm_defines.svh"

module mm_signed_mult import mm_pkg::*; (
  input  logic  CLK,
  input  logic  RST,
  input  word_t in_a,
  input  word_t in_b,
  input  logic  enable,
  output word_t rslt,    // low product word
  output logic  valid
);

  localparam int LAT  = `MM_MULT_LATENCY;
  localparam int PIPE = LAT - 2;  // product delay stages

  word_t          mag_a;
  word_t          mag_b;
  word_t          prod_q [PIPE];
  logic [LAT-2:0] neg_sr;        // sign travels with data
  logic [LAT-1:0] valid_sr;

  function automatic word_t absolute(word_t v);
    return v[`MM_W_D-1] ? (~v + 1'b1) : v;
  endfunction

  always_ff @(posedge CLK) begin
    mag_a     <= absolute(in_a);              // stage 1
    mag_b     <= absolute(in_b);
    prod_q[0] <= mag_a * mag_b;               // stage 2, low word only
    for (int i = 1; i < PIPE; i++) begin
      prod_q[i] <= prod_q[i-1];
    end
    neg_sr <= {neg_sr[LAT-3:0], in_a[`MM_W_D-1] ^ in_b[`MM_W_D-1]};
    // last stage fixes the sign
    rslt <= neg_sr[LAT-2] ? (~prod_q[PIPE-1] + 1'b1) : prod_q[PIPE-1];
  end

  always_ff @(posedge CLK) begin
    if (RST) begin
      valid_sr <= '0;
    end else begin
      valid_sr <= {valid_sr[LAT-2:0], enable};
    end
  end

  assign valid = valid_sr[LAT-1];

endmodule

`default_nettype wire

/* logic/mm_lane_acc.sv */
`default_nettype none

`include "mm_defines.svh"

module mm_lane_acc import mm_pkg::*; (
  input  logic      CLK,
  input  logic      RST,
  input  logic      op_valid,
  input  lane_vec_t op_a,
  input  lane_vec_t op_b,
  input  logic      session_clear,
  input  word_t     matrix_size,
  output logic      row_done,
  output lane_vec_t row_sums
);

  word_t              prod [`MM_SIMD];
  word_t              acc  [`MM_SIMD];
  logic [`MM_SIMD-1:0] mult_valid;
  word_t              elem_cnt;  // first element of current lane word
  logic               step;
  logic               row_end;

  for (genvar i = 0; i < `MM_SIMD; i++) begin : g_lane
    mm_signed_mult u_mult (
      .CLK    (CLK),
      .RST    (RST),
      .in_a   (op_a[i*`MM_W_D +: `MM_W_D]),
      .in_b   (op_b[i*`MM_W_D +: `MM_W_D]),
      .enable (op_valid),
      .rslt   (prod[i]),
      .valid  (mult_valid[i])
    );
  end

  assign step    = &mult_valid;  // lanes run in lockstep
  assign row_end = (elem_cnt == matrix_size - `MM_SIMD);

  always_ff @(posedge CLK) begin
    if (RST) begin
      row_done <= 1'b0;
      elem_cnt <= '0;
      for (int i = 0; i < `MM_SIMD; i++) acc[i] <= '0;
    end else begin
      row_done <= 1'b0;
      if (session_clear) begin
        elem_cnt <= '0;
        for (int i = 0; i < `MM_SIMD; i++) acc[i] <= '0;
      end else if (step) begin
        if (row_end) begin
          elem_cnt <= '0;
          row_done <= 1'b1;
          for (int i = 0; i < `MM_SIMD; i++) acc[i] <= '0;  // next row
        end else begin
          elem_cnt <= elem_cnt + `MM_SIMD;
          for (int i = 0; i < `MM_SIMD; i++) acc[i] <= acc[i] + prod[i];
        end
      end
    end
  end

  // final partial sum includes the last product
  always_ff @(posedge CLK) begin
    if (step && row_end) begin
      for (int i = 0; i < `MM_SIMD; i++) begin
        row_sums[i*`MM_W_D +: `MM_W_D] <= acc[i] + prod[i];
      end
    end
  end

endmodule

`default_nettype wire

/* logic/mm_row_writer.sv */
`default_nettype none

`include "mm_defines.svh"

module mm_row_writer import mm_pkg::*; (
  input  logic       CLK,
  input  logic       RST,
  input  logic       row_done,
  input  lane_vec_t  row_sums,
  input  logic       session_clear,
  input  word_t      matrix_size,
  output logic       c_we,
  output lane_addr_t c_waddr,
  output lane_vec_t  c_wdata
);

  localparam int LVLS = (`MM_LOG_SIMD == 0) ? 1 : `MM_LOG_SIMD;

  lane_vec_t               tree_q [LVLS];  // adder tree levels
  logic [LVLS-1:0]         tree_v;
  word_t                   row_res;
  logic                    row_v;
  lane_vec_t               pack;
  logic [`MM_LOG_SIMD:0]   slot_cnt;
  lane_addr_t              c_last;

  // adds neighbouring lanes, result packed low
  function automatic lane_vec_t pair_add(lane_vec_t v);
    lane_vec_t r;
    r = '0;
    for (int j = 0; j < `MM_SIMD / 2; j++) begin
      r[j*`MM_W_D +: `MM_W_D] = v[2*j*`MM_W_D +: `MM_W_D] + v[(2*j+1)*`MM_W_D +: `MM_W_D];
    end
    return r;
  endfunction

  // ------------------------------------------------------------
  // reduction
  // ------------------------------------------------------------
  always_ff @(posedge CLK) begin
    tree_q[0] <= (`MM_LOG_SIMD == 0) ? row_sums : pair_add(row_sums);
    for (int l = 1; l < LVLS; l++) tree_q[l] <= pair_add(tree_q[l-1]);
  end

  always_ff @(posedge CLK) begin
    if (RST) tree_v <= '0;
    else     tree_v <= LVLS'({tree_v, row_done});  // top bit drops out
  end

  assign row_res = tree_q[LVLS-1][`MM_W_D-1:0];
  assign row_v   = tree_v[LVLS-1];
  assign c_last  = lane_addr_t'((matrix_size >> `MM_LOG_SIMD) - 1);
  assign c_wdata = pack;

  // ------------------------------------------------------------
  // packing into C words
  // ------------------------------------------------------------
  always_ff @(posedge CLK) begin
    if (row_v) pack <= (pack >> `MM_W_D) | (lane_vec_t'(row_res) << (`MM_W_D*(`MM_SIMD-1)));
  end

  always_ff @(posedge CLK) begin
    if (RST) begin
      c_we     <= 1'b0;
      c_waddr  <= '0;
      slot_cnt <= '0;
    end else begin
      c_we <= 1'b0;
      if (session_clear) begin
        c_waddr  <= '0;
        slot_cnt <= '0;
      end else begin
        if (c_we) c_waddr <= (c_waddr == c_last) ? '0 : c_waddr + 1'b1;  // wrap at N/SIMD
        if (row_v) begin
          if (slot_cnt == `MM_SIMD - 1) begin
            slot_cnt <= '0;
            c_we     <= 1'b1;  // word full
          end else begin
            slot_cnt <= slot_cnt + 1'b1;
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

/* logic/mm_top.sv */
`default_nettype none

module mm_top import mm_pkg::*; (
  input  logic       CLK,
  input  logic       RST,
  input  logic       cmd_enq,
  input  word_t      cmd_data,
  output logic       cmd_full,
  input  logic       reply_deq,
  output logic       reply_empty,
  output word_t      reply_data,
  input  logic       a_we,
  input  lane_addr_t a_addr,
  input  lane_vec_t  a_data,
  input  logic       b_we,
  input  lane_addr_t b_addr,
  input  lane_vec_t  b_data,
  input  lane_addr_t c_raddr,
  output lane_vec_t  c_rdata
);

  word_t      cmd_q;
  logic       cmd_empty;
  logic       cmd_deq;
  logic       seq_reply_enq;
  word_t      seq_reply_data;
  lane_addr_t a_raddr;
  lane_addr_t b_raddr;
  lane_vec_t  a_rdata;
  lane_vec_t  b_rdata;
  logic       op_valid;
  lane_vec_t  op_a;
  lane_vec_t  op_b;
  logic       session_clear;
  word_t      matrix_size;
  logic       row_done;
  lane_vec_t  row_sums;
  logic       c_we;
  lane_addr_t c_waddr;
  lane_vec_t  c_wdata;

  // ------------------------------------------------------------
  // host channels
  // ------------------------------------------------------------
  mm_word_fifo u_cmd_fifo (
    .CLK(CLK), .RST(RST),
    .enq(cmd_enq), .data(cmd_data), .deq(cmd_deq),
    .q(cmd_q), .empty(cmd_empty), .full(cmd_full)
  );

  mm_word_fifo u_reply_fifo (
    .CLK(CLK), .RST(RST),
    .enq(seq_reply_enq), .data(seq_reply_data), .deq(reply_deq),
    .q(reply_data), .empty(reply_empty), .full()  // host reads before next cmd
  );

  // vector, matrix and result memories
  mm_lane_ram u_mem_a (
    .CLK(CLK), .we(a_we), .waddr(a_addr), .wdata(a_data),
    .raddr(a_raddr), .rdata(a_rdata)
  );

  mm_lane_ram u_mem_b (
    .CLK(CLK), .we(b_we), .waddr(b_addr), .wdata(b_data),
    .raddr(b_raddr), .rdata(b_rdata)
  );

  mm_lane_ram u_mem_c (
    .CLK(CLK), .we(c_we), .waddr(c_waddr), .wdata(c_wdata),
    .raddr(c_raddr), .rdata(c_rdata)
  );

  // ------------------------------------------------------------
  // compute pipeline
  // ------------------------------------------------------------
  mm_sequencer u_seq (
    .CLK(CLK), .RST(RST),
    .cmd_q(cmd_q), .cmd_empty(cmd_empty), .cmd_deq(cmd_deq),
    .reply_enq(seq_reply_enq), .reply_data(seq_reply_data),
    .a_raddr(a_raddr), .b_raddr(b_raddr),
    .a_rdata(a_rdata), .b_rdata(b_rdata),
    .op_valid(op_valid), .op_a(op_a), .op_b(op_b),
    .session_clear(session_clear), .matrix_size(matrix_size)
  );

  mm_lane_acc u_lanes (
    .CLK(CLK), .RST(RST),
    .op_valid(op_valid), .op_a(op_a), .op_b(op_b),
    .session_clear(session_clear), .matrix_size(matrix_size),
    .row_done(row_done), .row_sums(row_sums)
  );

  mm_row_writer u_writer (
    .CLK(CLK), .RST(RST),
    .row_done(row_done), .row_sums(row_sums),
    .session_clear(session_clear), .matrix_size(matrix_size),
    .c_we(c_we), .c_waddr(c_waddr), .c_wdata(c_wdata)
  );

endmodule

`default_nettype wire

/* bench/mm_clkgen.sv */
`default_nettype none

module mm_clkgen (
  output logic CLK,
  output logic RST
);

  localparam int HALF_PERIOD = 50;  // period 100
  localparam int RST_CYCLES  = 5;

  initial begin
    CLK = 1'b0;
    forever #HALF_PERIOD CLK = ~CLK;
  end

  // sync reset held over the first rising edges
  initial begin
    RST = 1'b1;
    repeat (RST_CYCLES) @(posedge CLK);
    #5 RST = 1'b0;  // off the edge, ahead of the bench drive point
  end

endmodule

`default_nettype wire

/* bench/mm_tb.sv */
`default_nettype none

`include "mm_defines.svh"

module mm_tb import mm_pkg::*; ();

  localparam int DRIVE_DELAY = 10;   // after rising edge
  localparam int WAIT_LIMIT  = 200;  // cycles per wait loop

  logic       CLK;
  logic       RST;
  logic       cmd_enq;
  word_t      cmd_data;
  logic       cmd_full;
  logic       reply_deq;
  logic       reply_empty;
  word_t      reply_data;
  logic       a_we;
  lane_addr_t a_addr;
  lane_vec_t  a_data;
  logic       b_we;
  lane_addr_t b_addr;
  lane_vec_t  b_data;
  lane_addr_t c_raddr;
  lane_vec_t  c_rdata;

  logic [31:0] lfsr_state;
  int          vec_a [128];                // element k of the vector
  int          mat_b [2][`MM_SIMD][128];   // page, row, element
  word_t       replies [3];
  int          errors;
  int          checks;
  int          tests;
  int          test_start_errs;

  mm_clkgen u_clk (.CLK(CLK), .RST(RST));

  mm_top uut (
    .CLK(CLK), .RST(RST),
    .cmd_enq(cmd_enq), .cmd_data(cmd_data), .cmd_full(cmd_full),
    .reply_deq(reply_deq), .reply_empty(reply_empty), .reply_data(reply_data),
    .a_we(a_we), .a_addr(a_addr), .a_data(a_data),
    .b_we(b_we), .b_addr(b_addr), .b_data(b_data),
    .c_raddr(c_raddr), .c_rdata(c_rdata)
  );

  // ------------------------------------------------------------
  // random operands, fibonacci lfsr x^32+x^22+x^2+x+1
  // ------------------------------------------------------------
  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function logic [31:0] draw_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);  // one step per bit
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  function int draw_operand();
    logic [31:0] raw;
    if (draw_bits(1) != 0) begin
      raw = draw_bits(8);
      draw_operand = int'({{24{raw[7]}}, raw[7:0]});  // small, either sign
    end else begin
      draw_operand = int'(draw_bits(32));
    end
  endfunction

  // reference row result, low 32 bits of the signed dot product
  function automatic int row_result(int page, int row, int n);
    int sum;
    sum = 0;
    for (int k = 0; k < n; k++) sum += vec_a[k] * mat_b[page][row][k];
    return sum;
  endfunction

  // ------------------------------------------------------------
  // host side tasks
  // ------------------------------------------------------------
  task automatic next_cycle();
    @(posedge CLK);
    #DRIVE_DELAY;
  endtask

  task automatic abort_run(string why);
    $display("timeout: %s at t=%0t", why, $time);
    $display("STATUS: FAIL");
    $finish;
  endtask

  task automatic check_value(string name, word_t exp, word_t got);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("ERR t=%0t %s expected %h got %h", $time, name, exp, got);
    end
  endtask

  task automatic check_rising(word_t prev, word_t cur);
    checks++;
    assert (cur > prev) else begin
      errors++;
      $display("reply count did not grow at t=%0t: %0d came after %0d", $time, cur, prev);
    end
  endtask

  task automatic finish_test(string name);
    tests++;
    $display("test %0d %s: %s", tests, name, (errors == test_start_errs) ? "ok" : "failed");
    test_start_errs = errors;
  endtask

  task automatic load_vector(int n);
    for (int k = 0; k < n; k++) vec_a[k] = draw_operand();
    vec_a[0] = -int'(draw_bits(4)) - 1;  // at least one negative
    for (int j = 0; j < n / `MM_SIMD; j++) begin
      a_we   = 1'b1;
      a_addr = lane_addr_t'(j);
      for (int i = 0; i < `MM_SIMD; i++) a_data[i*`MM_W_D +: `MM_W_D] = vec_a[j*`MM_SIMD + i];
      next_cycle();
    end
    a_we = 1'b0;
  endtask

  // rows 0 and 1 of a page, page 1 at the half-space base
  task automatic load_page(int page, int n);
    int base;
    base = page << (`MM_W_MEM_A - 1);
    for (int r = 0; r < `MM_SIMD; r++) begin
      for (int k = 0; k < n; k++) mat_b[page][r][k] = draw_operand();
      for (int j = 0; j < n / `MM_SIMD; j++) begin
        b_we   = 1'b1;
        b_addr = lane_addr_t'(base + r * (n / `MM_SIMD) + j);
        for (int i = 0; i < `MM_SIMD; i++) begin
          b_data[i*`MM_W_D +: `MM_W_D] = mat_b[page][r][j*`MM_SIMD + i];
        end
        next_cycle();
      end
    end
    b_we = 1'b0;
  endtask

  task automatic send_cmd(word_t w);
    int waited;
    waited = 0;
    while (cmd_full && waited < WAIT_LIMIT) begin
      next_cycle();
      waited++;
    end
    if (cmd_full) abort_run("command FIFO stayed full");
    cmd_enq  = 1'b1;
    cmd_data = w;
    next_cycle();
    cmd_enq  = 1'b0;
  endtask

  task automatic take_reply(output word_t v);
    int waited;
    waited = 0;
    while (reply_empty && waited < WAIT_LIMIT) begin
      next_cycle();
      waited++;
    end
    if (reply_empty) abort_run("no reply arrived");
    reply_deq = 1'b1;
    next_cycle();      // q loads on this edge
    reply_deq = 1'b0;
    v = reply_data;
  endtask

  // one C word holds rows 0..SIMD-1 of the batch's page
  task automatic check_c_word(int addr, int page, int n);
    c_raddr = lane_addr_t'(addr);
    next_cycle();
    for (int i = 0; i < `MM_SIMD; i++) begin
      check_value($sformatf("c_rdata C[%0d] lane %0d", addr, i),
                  word_t'(row_result(page, i, n)), c_rdata[i*`MM_W_D +: `MM_W_D]);
    end
  endtask

  // ------------------------------------------------------------
  // test sequence
  // ------------------------------------------------------------
  initial begin
    int waited;
    lfsr_state = 32'hc2e9;
    cmd_enq    = 1'b0;
    cmd_data   = '0;
    reply_deq  = 1'b0;
    a_we       = 1'b0;
    a_addr     = '0;
    a_data     = '0;
    b_we       = 1'b0;
    b_addr     = '0;
    b_data     = '0;
    c_raddr    = '0;
    errors     = 0;
    checks     = 0;
    tests      = 0;
    test_start_errs = 0;

    waited = 0;
    while (RST !== 1'b0 && waited < WAIT_LIMIT) begin
      next_cycle();
      waited++;
    end
    if (RST !== 1'b0) abort_run("reset never released");
    next_cycle();

    check_value("reply_empty", 1, reply_empty);
    check_value("cmd_full", 0, cmd_full);
    finish_test("flags after reset");

    load_vector(8);
    load_page(0, 8);
    load_page(1, 8);
    send_cmd(8);  // size
    send_cmd(8);  // two rows of four lane words
    take_reply(replies[0]);
    check_c_word(0, 0, 8);
    finish_test("n=8 batch from page 0");

    send_cmd(8);
    take_reply(replies[1]);
    check_c_word(1, 1, 8);  // A wrapped, same vector
    finish_test("second batch from page 1");

    check_rising(replies[0], replies[1]);
    finish_test("replies grow within session");

    load_vector(8);
    load_page(0, 8);
    send_cmd(0);  // end session
    send_cmd(8);
    send_cmd(8);
    take_reply(replies[2]);
    check_c_word(0, 0, 8);
    finish_test("session restart");

    // n=4 gives a two word C space
    load_vector(4);
    load_page(0, 4);
    load_page(1, 4);
    send_cmd(0);
    send_cmd(4);
    send_cmd(4);
    take_reply(replies[0]);
    check_c_word(0, 0, 4);
    send_cmd(4);
    take_reply(replies[1]);
    check_c_word(1, 1, 4);
    load_page(0, 4);  // fresh rows for the wrapped write
    send_cmd(4);
    take_reply(replies[2]);
    check_c_word(0, 0, 4);
    check_c_word(1, 1, 4);
    check_rising(replies[0], replies[1]);
    check_rising(replies[1], replies[2]);
    finish_test("C address wrap at n=4");

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
+incdir+logic
logic/mm_pkg.sv
logic/mm_word_fifo.sv
logic/mm_lane_ram.sv
logic/mm_sequencer.sv
logic/mm_signed_mult.sv
logic/mm_lane_acc.sv
logic/mm_row_writer.sv
logic/mm_top.sv
bench/mm_clkgen.sv
bench/mm_tb.sv

/* Bender.yml */
package:
  name: mm_engine

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/mm_pkg.sv
      - logic/mm_word_fifo.sv
      - logic/mm_lane_ram.sv
      - logic/mm_sequencer.sv
      - logic/mm_signed_mult.sv
      - logic/mm_lane_acc.sv
      - logic/mm_row_writer.sv
      - logic/mm_top.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - bench/mm_clkgen.sv
      - bench/mm_tb.sv
